/* project.f */
+incdir+rtl
+incdir+testbench
rtl/coeff_token_pkg.sv
rtl/coeff_token_window.sv
rtl/chroma_dc_vlc.sv
rtl/mid_nc_vlc.sv
rtl/high_nc_flc.sv
rtl/coeff_token_result.sv
rtl/coeff_token_decoder.sv
testbench/tb_coeff_token.sv

/* rtl/chroma_dc_vlc.sv */
/*
  Chroma DC column (nC = -1), combinational.
  An all-zero window, not a legal code, returns the 0000000 entry.
*/
`include "coeff_token_settings.svh"

`timescale 1ns/10ps
`default_nettype none

module chroma_dc_vlc
	import coeff_token_pkg::*;
(
	input  logic [0:`CHROMA_DC_WIN-1] window,
	output coeff_token_t              token
);

	logic [3:0]                lead;
	logic [0:`CHROMA_DC_WIN-1] aligned;
	logic [0:1]                suffix;

	// position of the first one, window length when there is none
	always_comb begin
		lead = 4'(`CHROMA_DC_WIN);
		for (int i = `CHROMA_DC_WIN - 1; i >= 0; i--) begin
			if (window[i])
				lead = 4'(i);
		end
	end

	assign aligned = window << lead;
	assign suffix = aligned[1:2];

	// entries are {total_coeff, trailing_ones, len}
	always_comb begin
		case (lead)
			4'd0: token = '{5'd1, 2'd1, 5'd1};
			4'd1: token = '{5'd0, 2'd0, 5'd2};
			4'd2: token = '{5'd2, 2'd2, 5'd3};
			4'd3:
				case (suffix)
					2'b11:   token = '{5'd1, 2'd0, 5'd6};
					2'b00:   token = '{5'd2, 2'd0, 5'd6};
					2'b10:   token = '{5'd2, 2'd1, 5'd6};
					default: token = '{5'd3, 2'd3, 5'd6};
				endcase
			4'd4: token = suffix[0] ? '{5'd3, 2'd0, 5'd6} : '{5'd4, 2'd0, 5'd6};
			4'd5: token = suffix[0] ? '{5'd3, 2'd1, 5'd7} : '{5'd3, 2'd2, 5'd7};
			4'd6: token = suffix[0] ? '{5'd4, 2'd1, 5'd8} : '{5'd4, 2'd2, 5'd8};
			// seven leading zeros
			default: token = '{5'd4, 2'd3, 5'd7};
		endcase
	end

endmodule

`default_nettype wire

/* rtl/coeff_token_decoder.sv */
/*
  CAVLC coeff_token decoder for chroma DC and nC >= 4.
  Capture with ena and start, load the count pair with ena and sel.
*/
`include "coeff_token_settings.svh"

`timescale 1ns/10ps
`default_nettype none

module coeff_token_decoder
	import coeff_token_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      ena,
	input  logic                      start,
	input  logic                      sel,
	input  logic [0:`RBSP_W-1]        rbsp,
	input  logic signed [`NC_W-1:0]   nc,
	output coeff_token_t              token_comb,
	output logic [`COEFF_TOTAL_W-1:0] total_coeff,
	output logic [`COEFF_T1_W-1:0]    trailing_ones
);

	rbsp_windows_t windows;
	nc_class_e     nc_class;
	coeff_token_t  chroma_dc_token;
	coeff_token_t  mid_token;
	coeff_token_t  high_token;

	coeff_token_window u_window (
		.clk      (clk),
		.rst_n    (rst_n),
		.ena      (ena),
		.start    (start),
		.rbsp     (rbsp),
		.nc       (nc),
		.windows  (windows),
		.nc_class (nc_class)
	);

	// --------------------
	// table columns
	// --------------------
	chroma_dc_vlc u_chroma_dc (.window(windows.chroma_dc), .token(chroma_dc_token));
	mid_nc_vlc    u_mid       (.window(windows.mid), .token(mid_token));
	high_nc_flc   u_high      (.window(windows.high), .token(high_token));

	coeff_token_result u_result (
		.clk             (clk),
		.rst_n           (rst_n),
		.ena             (ena),
		.sel             (sel),
		.nc_class        (nc_class),
		.chroma_dc_token (chroma_dc_token),
		.mid_token       (mid_token),
		.high_token      (high_token),
		.token_comb      (token_comb),
		.total_coeff     (total_coeff),
		.trailing_ones   (trailing_ones)
	);

endmodule

`default_nettype wire

/* rtl/coeff_token_pkg.sv */
/*
  Types shared by the coeff_token decoder.
  Windows keep bit 0 as the first bit of the stream.
*/
`include "coeff_token_settings.svh"

`default_nettype none

package coeff_token_pkg;

	// decoded coeff_token, 12 bits
	typedef struct packed {
		logic [`COEFF_TOTAL_W-1:0] total_coeff;
		logic [`COEFF_T1_W-1:0]    trailing_ones;
		logic [`COEFF_LEN_W-1:0]   len;
	} coeff_token_t;

	// captured look-ahead per table column, 24 bits
	typedef struct packed {
		logic [0:`CHROMA_DC_WIN-1] chroma_dc;
		logic [0:`MID_NC_WIN-1]    mid;
		logic [0:`HIGH_NC_WIN-1]   high;
	} rbsp_windows_t;

	// table column picked by nC
	typedef enum logic [1:0] {
		class_chroma_dc,
		class_mid,
		class_high
	} nc_class_e;

endpackage

`default_nettype wire

/* rtl/coeff_token_result.sv */
/*
  Picks the token of the active column and holds the registered count pair.
  len is only given combinationally.
*/
`include "coeff_token_settings.svh"

`timescale 1ns/10ps
`default_nettype none

module coeff_token_result
	import coeff_token_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      ena,
	input  logic                      sel,
	input  nc_class_e                 nc_class,
	input  coeff_token_t              chroma_dc_token,
	input  coeff_token_t              mid_token,
	input  coeff_token_t              high_token,
	output coeff_token_t              token_comb,
	output logic [`COEFF_TOTAL_W-1:0] total_coeff,
	output logic [`COEFF_T1_W-1:0]    trailing_ones
);

	logic load;

	// --------------------
	// output mux
	// --------------------
	always_comb begin
		case (nc_class)
			class_chroma_dc: token_comb = chroma_dc_token;
			class_high:      token_comb = high_token;
			default:         token_comb = mid_token;
		endcase
	end

	assign load = ena & sel;

	// count pair, holds until the next load
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			total_coeff <= '0;
			trailing_ones <= '0;
		end else if (load) begin
			total_coeff <= token_comb.total_coeff;
			trailing_ones <= token_comb.trailing_ones;
		end
	end

endmodule

`default_nettype wire

/* rtl/coeff_token_settings.svh */
/*
  Bit widths and window lengths for the coeff_token decoder.
  Look-ahead and window vectors are numbered with bit 0 as the first stream bit.
*/
`ifndef COEFF_TOKEN_SETTINGS_SVH
`define COEFF_TOKEN_SETTINGS_SVH

// token fields
`define COEFF_TOTAL_W 5
`define COEFF_T1_W 2
`define COEFF_LEN_W 5

// nC is signed, -1 selects chroma DC
`define NC_W 5

// look-ahead and per-column windows
`define RBSP_W 16
`define CHROMA_DC_WIN 8
`define MID_NC_WIN 10
`define HIGH_NC_WIN 6

`endif

/* rtl/coeff_token_window.sv */
/*
  Legal nC is -1 or 4..16. nC = 16 wraps onto the sign bit of the 5-bit field,
  so only the all-ones pattern counts as chroma DC. nC of 0..3 lands in the middle column.
*/
`include "coeff_token_settings.svh"

`timescale 1ns/10ps
`default_nettype none

module coeff_token_window
	import coeff_token_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     ena,
	input  logic                     start,
	input  logic [0:`RBSP_W-1]       rbsp,
	input  logic signed [`NC_W-1:0]  nc,
	output rbsp_windows_t            windows,
	output nc_class_e                nc_class
);

	logic capture;

	// --------------------
	// column select
	// --------------------
	always_comb begin
		if (&nc)
			nc_class = class_chroma_dc;
		else if (nc[4] | nc[3])
			nc_class = class_high;
		else
			nc_class = class_mid;
	end

	assign capture = ena & start;

	// --------------------
	// window capture
	// --------------------
	// only the selected column reloads, the other two hold their last window
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			windows <= '0;
		end else if (capture) begin
			case (nc_class)
				class_chroma_dc: windows.chroma_dc <= rbsp[0:`CHROMA_DC_WIN-1];
				class_high:      windows.high <= rbsp[0:`HIGH_NC_WIN-1];
				default:         windows.mid <= rbsp[0:`MID_NC_WIN-1];
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/high_nc_flc.sv */
/*
  Fixed-length column for nC >= 8. Every code is 6 bits.
*/
`include "coeff_token_settings.svh"

`timescale 1ns/10ps
`default_nettype none

module high_nc_flc
	import coeff_token_pkg::*;
(
	input  logic [0:`HIGH_NC_WIN-1] window,
	output coeff_token_t            token
);

	always_comb begin
		token.len = `COEFF_LEN_W'(`HIGH_NC_WIN);
		// 000011 is the only code for an empty block
		if (window == 6'b000011) begin
			token.total_coeff = '0;
			token.trailing_ones = '0;
		end else begin
			token.total_coeff = {1'b0, window[0:3]} + 5'd1;
			token.trailing_ones = window[4:5];
		end
	end

endmodule

`default_nettype wire

/* rtl/mid_nc_vlc.sv */
/*
  coeff_token column for 4 <= nC < 8, combinational. Codes are 4 to 10 bits.
  An all-zero window is treated as the 0000000001 entry, 16 coefficients.
*/
`include "coeff_token_settings.svh"

`timescale 1ns/10ps
`default_nettype none

module mid_nc_vlc
	import coeff_token_pkg::*;
(
	input  logic [0:`MID_NC_WIN-1] window,
	output coeff_token_t           token
);

	logic [3:0]             lead;
	logic [0:`MID_NC_WIN-1] aligned;
	logic [0:2]             suffix;

	always_comb begin
		lead = 4'(`MID_NC_WIN);
		for (int i = `MID_NC_WIN - 1; i >= 0; i--) begin
			if (window[i])
				lead = 4'(i);
		end
	end

	// bits that follow the leading one
	assign aligned = window << lead;
	assign suffix = aligned[1:3];

	// entries are {total_coeff, trailing_ones, len}
	always_comb begin
		case (lead)
			4'd0:
				case (suffix)
					3'b111:  token = '{5'd0, 2'd0, 5'd4};
					3'b110:  token = '{5'd1, 2'd1, 5'd4};
					3'b101:  token = '{5'd2, 2'd2, 5'd4};
					3'b100:  token = '{5'd3, 2'd3, 5'd4};
					3'b011:  token = '{5'd4, 2'd3, 5'd4};
					3'b010:  token = '{5'd5, 2'd3, 5'd4};
					3'b001:  token = '{5'd6, 2'd3, 5'd4};
					default: token = '{5'd7, 2'd3, 5'd4};
				endcase
			4'd1:
				case (suffix)
					3'b111:  token = '{5'd2, 2'd1, 5'd5};
					3'b100:  token = '{5'd3, 2'd1, 5'd5};
					3'b110:  token = '{5'd3, 2'd2, 5'd5};
					3'b010:  token = '{5'd4, 2'd1, 5'd5};
					3'b011:  token = '{5'd4, 2'd2, 5'd5};
					3'b000:  token = '{5'd5, 2'd1, 5'd5};
					3'b001:  token = '{5'd5, 2'd2, 5'd5};
					default: token = '{5'd8, 2'd3, 5'd5};
				endcase
			4'd2:
				case (suffix)
					3'b111:  token = '{5'd1, 2'd0, 5'd6};
					3'b011:  token = '{5'd2, 2'd0, 5'd6};
					3'b000:  token = '{5'd3, 2'd0, 5'd6};
					3'b110:  token = '{5'd6, 2'd1, 5'd6};
					3'b101:  token = '{5'd6, 2'd2, 5'd6};
					3'b010:  token = '{5'd7, 2'd1, 5'd6};
					3'b001:  token = '{5'd7, 2'd2, 5'd6};
					default: token = '{5'd9, 2'd3, 5'd6};
				endcase
			4'd3:
				case (suffix)
					3'b111:  token = '{5'd4, 2'd0, 5'd7};
					3'b011:  token = '{5'd5, 2'd0, 5'd7};
					3'b001:  token = '{5'd6, 2'd0, 5'd7};
					3'b000:  token = '{5'd7, 2'd0, 5'd7};
					3'b110:  token = '{5'd8, 2'd1, 5'd7};
					3'b101:  token = '{5'd8, 2'd2, 5'd7};
					3'b010:  token = '{5'd9, 2'd2, 5'd7};
					default: token = '{5'd10, 2'd3, 5'd7};
				endcase
			4'd4:
				case (suffix)
					3'b111:  token = '{5'd8, 2'd0, 5'd8};
					3'b011:  token = '{5'd9, 2'd0, 5'd8};
					3'b110:  token = '{5'd9, 2'd1, 5'd8};
					3'b010:  token = '{5'd10, 2'd1, 5'd8};
					3'b101:  token = '{5'd10, 2'd2, 5'd8};
					3'b001:  token = '{5'd11, 2'd2, 5'd8};
					3'b100:  token = '{5'd11, 2'd3, 5'd8};
					default: token = '{5'd12, 2'd3, 5'd8};
				endcase
			4'd5:
				case (suffix)
					3'b111:  token = '{5'd10, 2'd0, 5'd9};
					3'b011:  token = '{5'd11, 2'd0, 5'd9};
					3'b110:  token = '{5'd11, 2'd1, 5'd9};
					3'b000:  token = '{5'd12, 2'd0, 5'd9};
					3'b010:  token = '{5'd12, 2'd1, 5'd9};
					3'b101:  token = '{5'd12, 2'd2, 5'd9};
					3'b001:  token = '{5'd13, 2'd2, 5'd9};
					default: token = '{5'd13, 2'd3, 5'd9};
				endcase
			// only 0000001 mixes 9 and 10 bit codes
			4'd6:
				casez (suffix)
					3'b11?:  token = '{5'd13, 2'd1, 5'd9};
					3'b101:  token = '{5'd13, 2'd0, 5'd10};
					3'b001:  token = '{5'd14, 2'd0, 5'd10};
					3'b100:  token = '{5'd14, 2'd1, 5'd10};
					3'b011:  token = '{5'd14, 2'd2, 5'd10};
					3'b010:  token = '{5'd14, 2'd3, 5'd10};
					default: token = '{5'd15, 2'd1, 5'd10};
				endcase
			4'd7:
				case (suffix[0:1])
					2'b01:   token = '{5'd15, 2'd0, 5'd10};
					2'b11:   token = '{5'd15, 2'd2, 5'd10};
					2'b10:   token = '{5'd15, 2'd3, 5'd10};
					default: token = '{5'd16, 2'd1, 5'd10};
				endcase
			4'd8: token = suffix[0] ? '{5'd16, 2'd2, 5'd10} : '{5'd16, 2'd3, 5'd10};
			default: token = '{5'd16, 2'd0, 5'd10};
		endcase
	end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build and run the coeff_token testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
	-f project.f --top-module tb_coeff_token -o tb_coeff_token
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out="$(./obj_dir/tb_coeff_token)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF '*** TEST PASSED ***' <<< "$out"; then
	exit 0
fi
exit 1

/* testbench/tb_coeff_token_model.svh */
/*
  Reference coeff_token columns built from the H.264 table, rows by TotalCoeff 0..16.
  Each row lists the codes for TrailingOnes 0..3, a dash where no code exists.
*/
`ifndef TB_COEFF_TOKEN_MODEL_SVH
`define TB_COEFF_TOKEN_MODEL_SVH

function automatic string code_row(input bit chroma, input int tc);
	if (chroma) begin
		case (tc)
			0:       return "01 - - -";
			1:       return "000111 1 - -";
			2:       return "000100 000110 001 -";
			3:       return "000011 0000011 0000010 000101";
			4:       return "000010 00000011 00000010 0000000";
			default: return "- - - -";
		endcase
	end
	// column for 4 <= nC < 8
	case (tc)
		0:       return "1111 - - -";
		1:       return "001111 1110 - -";
		2:       return "001011 01111 1101 -";
		3:       return "001000 01100 01110 1100";
		4:       return "0001111 01010 01011 1011";
		5:       return "0001011 01000 01001 1010";
		6:       return "0001001 001110 001101 1001";
		7:       return "0001000 001010 001001 1000";
		8:       return "00001111 0001110 0001101 01101";
		9:       return "00001011 00001110 0001010 001100";
		10:      return "000001111 00001010 00001101 0001100";
		11:      return "000001011 000001110 00001001 00001100";
		12:      return "000001000 000001010 000001101 00001000";
		13:      return "0000001101 000000111 000001001 000001100";
		14:      return "0000001001 0000001100 0000001011 0000001010";
		15:      return "0000000101 0000001000 0000000111 0000000110";
		16:      return "0000000001 0000000100 0000000011 0000000010";
		default: return "- - - -";
	endcase
endfunction

// bits[15] is the first stream bit, the code that prefixes it wins
function automatic coeff_token_t table_ref(input bit chroma, input logic [15:0] bits,
		input coeff_token_t fallback);
	coeff_token_t t;
	string        row;
	int           t1;
	int           n;
	bit           ok;
	t = fallback;
	for (int tc = 0; tc <= 16; tc++) begin
		row = code_row(chroma, tc);
		t1 = 0;
		n = 0;
		ok = 1'b1;
		for (int i = 0; i <= row.len(); i++) begin
			if (i == row.len() || row[i] == " ") begin
				if (ok && n > 0)
					t = '{5'(tc), 2'(t1), 5'(n)};
				t1++;
				n = 0;
				ok = 1'b1;
			end else if (row[i] == "-" || bits[15 - n] != (row[i] == "1")) begin
				ok = 1'b0;
			end else begin
				n++;
			end
		end
	end
	return t;
endfunction

function automatic coeff_token_t chroma_dc_ref(input logic [0:7] w);
	return table_ref(1'b1, {w, 8'b0}, '{5'd4, 2'd3, 5'd7});
endfunction

// all-zero window counts as 0000000001
function automatic coeff_token_t mid_ref(input logic [0:9] w);
	return table_ref(1'b0, {w, 6'b0}, '{5'd16, 2'd0, 5'd10});
endfunction

function automatic coeff_token_t high_ref(input logic [0:5] w);
	coeff_token_t t;
	t.len = 5'd6;
	if (w == 6'b000011) begin
		t.total_coeff = 5'd0;
		t.trailing_ones = 2'd0;
	end else begin
		t.total_coeff = 5'(w / 4 + 1);
		t.trailing_ones = 2'(w % 4);
	end
	return t;
endfunction

`endif

/* testbench/tb_coeff_token.sv */
/*
  Testbench for coeff_token_decoder, chroma DC and nC 4..16 only.
  Expected tokens come from the string table model in the included header.
*/
`include "coeff_token_settings.svh"

`timescale 1ns/10ps
`default_nettype none

module tb_coeff_token
	import coeff_token_pkg::*;
();

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 3;
	// each step takes two clocks
	localparam int STEPS = 3 + 256 + 1024 + 64 + 16 + 6;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 2 * STEPS + 50;
	localparam logic signed [`NC_W-1:0] NC_CHROMA = -5'sd1;

	logic                      clk;
	logic                      rst_n;
	logic                      ena;
	logic                      start;
	logic                      sel;
	logic [0:`RBSP_W-1]        rbsp;
	logic signed [`NC_W-1:0]   nc;
	coeff_token_t              token_comb;
	logic [`COEFF_TOTAL_W-1:0] total_coeff;
	logic [`COEFF_T1_W-1:0]    trailing_ones;

	integer                  seed;
	logic [31:0]             r;
	int                      checks;
	int                      errors;
	coeff_token_t            want;
	coeff_token_t            pair;
	logic signed [`NC_W-1:0] nc_pick;
	logic [0:5]              code;

	`include "tb_coeff_token_model.svh"

	coeff_token_decoder dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.ena           (ena),
		.start         (start),
		.sel           (sel),
		.rbsp          (rbsp),
		.nc            (nc),
		.token_comb    (token_comb),
		.total_coeff   (total_coeff),
		.trailing_ones (trailing_ones)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// drive at a rising edge, strobes act on the next one, sample at the falling edge
	task automatic run_step(input logic e, input logic s, input logic l,
			input logic signed [`NC_W-1:0] n, input logic [0:`RBSP_W-1] bits);
		@(posedge clk);
		ena <= e;
		start <= s;
		sel <= l;
		nc <= n;
		rbsp <= bits;
		@(posedge clk);
		start <= 1'b0;
		sel <= 1'b0;
		@(negedge clk);
	endtask

	task automatic check_token(input string name, input coeff_token_t exp_t);
		checks++;
		assert (token_comb == exp_t)
		else begin
			errors++;
			$display("Fail %s: expected %0d/%0d/%0d, actual %0d/%0d/%0d", name,
				exp_t.total_coeff, exp_t.trailing_ones, exp_t.len, token_comb.total_coeff,
				token_comb.trailing_ones, token_comb.len);
		end
	endtask

	task automatic check_pair(input string name, input coeff_token_t exp_t);
		checks++;
		assert ({total_coeff, trailing_ones} == {exp_t.total_coeff, exp_t.trailing_ones})
		else begin
			errors++;
			$display("Fail %s: expected %0d/%0d, actual %0d/%0d", name,
				exp_t.total_coeff, exp_t.trailing_ones, total_coeff, trailing_ones);
		end
	endtask

	task automatic finish_run(input bit timed_out);
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timed_out);
		if (errors == 0 && !timed_out)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	endtask

	initial begin
		seed = 32'h7015_085d;
		checks = 0;
		errors = 0;
		rst_n = 1'b0;
		ena = 1'b0;
		start = 1'b0;
		sel = 1'b0;
		rbsp = '0;
		nc = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);

		// --------------------
		// reset state
		// --------------------
		check_pair("reset_pair", '0);
		run_step(1'b1, 1'b0, 1'b0, NC_CHROMA, '0);
		check_token("reset_chroma_dc", chroma_dc_ref('0));
		run_step(1'b1, 1'b0, 1'b0, 5'd5, '0);
		check_token("reset_mid", mid_ref('0));
		run_step(1'b1, 1'b0, 1'b0, 5'd12, '0);
		check_token("reset_high", high_ref('0));

		// --------------------
		// full column sweeps
		// --------------------
		for (int i = 0; i < 256; i++) begin
			r = $random(seed);
			run_step(1'b1, 1'b1, 1'b0, NC_CHROMA, {8'(i), r[7:0]});
			check_token("chroma_dc", chroma_dc_ref(8'(i)));
		end
		// trailing rbsp bits are random and must not matter
		for (int i = 0; i < 1024; i++) begin
			r = $random(seed);
			run_step(1'b1, 1'b1, 1'b0, 5'(4 + r[9:8]), {10'(i), r[5:0]});
			check_token("mid", mid_ref(10'(i)));
		end
		for (int i = 0; i < 64; i++) begin
			r = $random(seed);
			run_step(1'b1, 1'b1, 1'b0, 5'(8 + r[31:24] % 9), {6'(i), r[9:0]});
			check_token("high", high_ref(6'(i)));
		end

		// --------------------
		// registered pair
		// --------------------
		for (int i = 0; i < 6; i++) begin
			r = $random(seed);
			case (i % 3)
				0: begin
					nc_pick = NC_CHROMA;
					want = chroma_dc_ref(r[15:8]);
				end
				1: begin
					nc_pick = 5'd6;
					want = mid_ref(r[15:6]);
				end
				default: begin
					nc_pick = 5'd11;
					want = high_ref(r[15:10]);
				end
			endcase
			run_step(1'b1, 1'b1, 1'b0, nc_pick, r[15:0]);
			check_token("pair_capture", want);
			run_step(1'b1, 1'b0, 1'b1, nc_pick, r[15:0]);
			pair = want;
			check_pair("pair_load", pair);
		end
		// new high code that decodes to a different count than the loaded one
		code = ~r[15:10];
		run_step(1'b1, 1'b1, 1'b0, nc_pick, {code, 10'b0});
		check_token("capture_sel_low", high_ref(code));
		// ena high with sel low while token_comb differs from the loaded pair
		run_step(1'b1, 1'b0, 1'b0, nc_pick, {code, 10'b0});
		check_pair("hold_sel_low", pair);
		run_step(1'b0, 1'b0, 1'b1, nc_pick, {code, 10'b0});
		check_pair("hold_ena_low", pair);
		run_step(1'b0, 1'b1, 1'b0, nc_pick, {~code, 10'b0});
		check_token("no_capture_ena_low", high_ref(code));

		// --------------------
		// window persistence
		// --------------------
		r = $random(seed);
		run_step(1'b1, 1'b1, 1'b0, NC_CHROMA, r[15:0]);
		check_token("persist_chroma_dc", chroma_dc_ref(r[15:8]));
		run_step(1'b1, 1'b1, 1'b0, 5'd7, r[31:16]);
		check_token("persist_mid", mid_ref(r[31:22]));
		// nC of 16 sits in the top bit of the field
		run_step(1'b1, 1'b1, 1'b0, 5'b10000, {r[5:0], r[25:16]});
		check_token("persist_high", high_ref(r[5:0]));
		run_step(1'b1, 1'b0, 1'b0, NC_CHROMA, ~r[15:0]);
		check_token("return_chroma_dc", chroma_dc_ref(r[15:8]));
		run_step(1'b1, 1'b0, 1'b0, 5'd4, ~r[31:16]);
		check_token("return_mid", mid_ref(r[31:22]));
		run_step(1'b1, 1'b0, 1'b0, 5'd8, ~{r[5:0], r[25:16]});
		check_token("return_high", high_ref(r[5:0]));

		finish_run(1'b0);
	end

	// watchdog
	initial begin
		#(CLK_PERIOD * WATCHDOG_CYCLES);
		$display("timeout: stimulus still running after %0d cycles", WATCHDOG_CYCLES);
		finish_run(1'b1);
	end

endmodule

`default_nettype wire
